//--- common/replica_pkg.sv
// replica data types
// generator state, costs and the best-result record shared by the data blocks

package replica_pkg;

    // xorshift64 generator state
    typedef logic [63:0] seed_t;

    // cost of a candidate or base distance of a replica
    typedef logic [31:0] total_data_t;

    // number of low state bits that are added to the base distance
    localparam int noise_width = 8;

    typedef logic [7:0] node_idx_t;

    // node sits above cost so that a readback gives the cost in the low word
    typedef struct packed {
        node_idx_t   node;
        total_data_t cost;
    } best_t;

endpackage

//--- common/bus_pkg.sv
// register map of the replica engine
// address regions and the command records that go from the bus slave to the data blocks

package bus_pkg;
    import replica_pkg::*;

    localparam logic [1:0] resp_okay = 2'b00;

    // taken from address bits 15:12
    typedef enum logic [3:0] {
        run_reg  = 4'h0,
        seed_reg = 4'h1,
        dist_reg = 4'h2,
        best_reg = 4'h4,
        none     = 4'hf
    } region_e;

    typedef struct packed {
        logic        strobe;
        region_e     region;
        node_idx_t   idx;
        logic [63:0] data;
    } wr_cmd_t;

    typedef struct packed {
        logic      strobe;
        region_e   region;
        node_idx_t idx;
    } rd_cmd_t;

    function automatic region_e decode_region(input logic [3:0] page);
        case (page)
            4'h0:    return run_reg;
            4'h1:    return seed_reg;
            4'h2:    return dist_reg;
            4'h4:    return best_reg;
            default: return none;
        endcase
    endfunction

endpackage

//--- bus_if/bus_if.sv
// AXI-Lite slave of the replica engine
// turns bus writes and reads into one-cycle command strobes and returns register data

module bus_if
    import replica_pkg::*;
    import bus_pkg::*;
#(
    parameter int node_num = 4
)(
    input  logic                 S_AXI_ACLK,
    input  logic                 S_AXI_ARESETN,

    input  logic [15:0]          awaddr_i,
    input  logic                 awvalid_i,
    output logic                 awready_o,
    input  logic [63:0]          wdata_i,
    input  logic [7:0]           wstrb_i,
    input  logic                 wvalid_i,
    output logic                 wready_o,
    output logic [1:0]           bresp_o,
    output logic                 bvalid_o,
    input  logic                 bready_i,

    input  logic [15:0]          araddr_i,
    input  logic                 arvalid_i,
    output logic                 arready_o,
    output logic [63:0]          rdata_o,
    output logic [1:0]           rresp_o,
    output logic                 rvalid_o,
    input  logic                 rready_i,

    input  seed_t [node_num-1:0] seeds_i,
    input  total_data_t          chain_head_i,
    input  best_t                best_i,
    input  logic                 running_i,

    output wr_cmd_t              wr_cmd_o,
    output rd_cmd_t              rd_cmd_o
);

    localparam int idx_w = $clog2(node_num);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp,
        st_read
    } state_e;

    state_e      state;
    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;
    logic        wr_done;
    logic        wr_go;
    logic        rd_phase;
    region_e     w_region;
    node_idx_t   w_idx;
    logic [63:0] w_data;
    logic        w_full;
    region_e     r_region;
    node_idx_t   r_idx;
    total_data_t head_q;
    logic [63:0] rd_sel;

    assign awready_o = (state == st_idle) || (state == st_data);
    assign wready_o  = (state == st_idle) || (state == st_addr);
    // a write arriving together with a read takes the slot first
    assign arready_o = (state == st_idle) && !awvalid_i && !wvalid_i;
    assign bvalid_o  = (state == st_resp);
    assign rvalid_o  = (state == st_read) && rd_phase;
    assign bresp_o   = resp_okay;
    assign rresp_o   = resp_okay;

    assign aw_hs = awvalid_i && awready_o;
    assign w_hs  = wvalid_i && wready_o;
    assign ar_hs = arvalid_i && arready_o;

    // both halves of the write are in once this cycle completes
    assign wr_done = (aw_hs || state == st_addr) && (w_hs || state == st_data);

    assign wr_cmd_o = wr_cmd_t'{strobe: wr_go, region: w_region, idx: w_idx, data: w_data};
    assign rd_cmd_o = rd_cmd_t'{strobe: ar_hs,
                                region: decode_region(araddr_i[15:12]),
                                idx:    araddr_i[10:3]};

    always_comb begin
        case (r_region)
            run_reg:  rd_sel = {63'b0, running_i};
            seed_reg: rd_sel = seeds_i[r_idx[idx_w-1:0]];
            dist_reg: rd_sel = {32'b0, head_q};
            best_reg: rd_sel = {24'b0, best_i};
            default:  rd_sel = '0;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            w_region <= decode_region(awaddr_i[15:12]);
            w_idx    <= awaddr_i[10:3];
        end
        if (w_hs) begin
            w_data <= wdata_i;
            w_full <= (wstrb_i == 8'hff);
        end
        // the chain rotates on the read strobe, so its head is taken before that
        if (ar_hs) begin
            r_region <= decode_region(araddr_i[15:12]);
            r_idx    <= araddr_i[10:3];
            head_q   <= chain_head_i;
        end
        if (state == st_read && !rd_phase) begin
            rdata_o <= rd_sel;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= st_idle;
            wr_go    <= 1'b0;
            rd_phase <= 1'b0;
        end else begin
            // partial strobe patterns complete on the bus but change nothing
            wr_go <= wr_done && (w_hs ? (wstrb_i == 8'hff) : w_full);
            case (state)
                st_idle: begin
                    if (wr_done) begin
                        state <= st_resp;
                    end else if (aw_hs) begin
                        state <= st_addr;
                    end else if (w_hs) begin
                        state <= st_data;
                    end else if (ar_hs) begin
                        state <= st_read;
                    end
                end
                st_addr, st_data: begin
                    if (wr_done) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (bready_i) begin
                        state <= st_idle;
                    end
                end
                st_read: begin
                    if (!rd_phase) begin
                        rd_phase <= 1'b1;
                    end else if (rready_i) begin
                        rd_phase <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_resp_excl: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(bvalid_o && rvalid_o));

    a_wr_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr_cmd_o.strobe |=> !wr_cmd_o.strobe);

    a_rd_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rd_cmd_o.strobe |=> !rd_cmd_o.strobe ##1 rvalid_o);

endmodule

//--- src/run_ctrl.sv
// run control of the replica engine
// starts a run on a step-count write and steps one replica per cycle until the last visit

module run_ctrl
    import bus_pkg::*;
(
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  wr_cmd_t     wr_cmd_i,
    input  logic        last_i,
    output logic        load_o,
    output logic [23:0] steps_o,
    output logic        step_o,
    output logic        cand_valid_o,
    output logic        clear_best_o,
    output logic        running_o
);

    typedef enum logic {
        st_idle,
        st_run
    } state_e;

    state_e state;
    logic   start;

    // a count of zero is accepted on the bus but never leaves idle
    assign start = (state == st_idle) && wr_cmd_i.strobe && (wr_cmd_i.region == run_reg)
                   && (wr_cmd_i.data[23:0] != 24'd0);

    assign load_o       = start;
    assign clear_best_o = start;
    assign steps_o      = wr_cmd_i.data[23:0];
    assign running_o    = (state == st_run);
    assign step_o       = running_o;
    // the candidate cost is formed in the same cycle as the visit
    assign cand_valid_o = step_o;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (start) state <= st_run;
                st_run:  if (last_i) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // the host waits for the end of a run before it writes again
    a_no_write_in_run: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        running_o |-> !wr_cmd_i.strobe);

    a_run_ends: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        step_o && last_i |=> !running_o);

endmodule

//--- src/step_counter.sv
// visit counter of a run
// walks the replica index round robin and counts the remaining sweeps down on each wrap

module step_counter
    import replica_pkg::*;
#(
    parameter int node_num = 4
)(
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        load_i,
    input  logic [23:0] steps_i,
    input  logic        step_i,
    output node_idx_t   index_o,
    output logic        last_o
);

    localparam node_idx_t last_idx = node_idx_t'(node_num - 1);

    node_idx_t   index;
    logic [23:0] remaining;

    assign index_o = index;
    assign last_o  = (remaining == 24'd1) && (index == last_idx);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            index     <= '0;
            remaining <= '0;
        end else if (load_i) begin
            index     <= '0;
            remaining <= steps_i;
        end else if (step_i) begin
            if (index == last_idx) begin
                index     <= '0;
                remaining <= remaining - 24'd1;
            end else begin
                index <= index + node_idx_t'(1);
            end
        end
    end

endmodule

//--- src/seed_bank.sv
// bank of per-replica xorshift64 generators
// the host loads seeds, a run advances the visited replica once per step

module seed_bank
    import replica_pkg::*;
    import bus_pkg::*;
#(
    parameter int node_num = 4
)(
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  wr_cmd_t                    wr_cmd_i,
    input  logic                       step_i,
    input  node_idx_t                  index_i,
    output logic [noise_width-1:0]     noise_o,
    output seed_t [node_num-1:0]       seeds_o
);

    localparam int idx_w = $clog2(node_num);

    seed_t [node_num-1:0] seeds;
    seed_t                next_seed;

    function automatic seed_t xorshift64(input seed_t s);
        seed_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    assign next_seed = xorshift64(seeds[index_i[idx_w-1:0]]);
    assign noise_o   = next_seed[noise_width-1:0];
    assign seeds_o   = seeds;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            seeds <= '0;
        end else if (wr_cmd_i.strobe && wr_cmd_i.region == seed_reg) begin
            seeds[wr_cmd_i.idx[idx_w-1:0]] <= wr_cmd_i.data;
        end else if (step_i) begin
            seeds[index_i[idx_w-1:0]] <= next_seed;
        end
    end

endmodule

//--- src/distance_chain.sv
// shift chain of per-replica base distances
// host pushes at the tail, a host read rotates the head to the tail

module distance_chain
    import replica_pkg::*;
    import bus_pkg::*;
#(
    parameter int node_num = 4
)(
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  wr_cmd_t     wr_cmd_i,
    input  rd_cmd_t     rd_cmd_i,
    input  node_idx_t   index_i,
    output total_data_t entry_o,
    output total_data_t head_o
);

    localparam int idx_w = $clog2(node_num);

    total_data_t [node_num-1:0] chain;
    logic                       push;
    logic                       rotate;

    assign push    = wr_cmd_i.strobe && (wr_cmd_i.region == dist_reg);
    assign rotate  = rd_cmd_i.strobe && (rd_cmd_i.region == dist_reg);
    assign head_o  = chain[0];
    assign entry_o = chain[index_i[idx_w-1:0]];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            chain <= '0;
        end else if (push || rotate) begin
            for (int i = 0; i < node_num - 1; i++) begin
                chain[i] <= chain[i+1];
            end
            chain[node_num-1] <= push ? wr_cmd_i.data[31:0] : chain[0];
        end
    end

endmodule

//--- src/min_tracker.sv
// running minimum of candidate costs
// keeps the lowest cost and its payload, the earliest one wins a tie

module min_tracker
    import replica_pkg::*;
#(
    parameter type payload_t = logic [7:0]
)(
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        clear_i,
    input  logic        valid_i,
    input  total_data_t cost_i,
    input  payload_t    payload_i,
    output total_data_t best_cost_o,
    output payload_t    best_payload_o
);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || clear_i) begin
            best_cost_o    <= '1;
            best_payload_o <= '0;
        end else if (valid_i && cost_i < best_cost_o) begin
            best_cost_o    <= cost_i;
            best_payload_o <= payload_i;
        end
    end

endmodule

//--- src/replica_top.sv
// replica engine top level
// AXI-Lite slave in front of the generators, the distance chain and the minimum search

module replica_top
    import replica_pkg::*;
    import bus_pkg::*;
#(
    parameter int node_num = 4
)(
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,

    input  logic [15:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [63:0] wdata_i,
    input  logic [7:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,

    input  logic [15:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [63:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i
);

    wr_cmd_t                wr_cmd;
    rd_cmd_t                rd_cmd;
    seed_t [node_num-1:0]   seeds;
    logic [noise_width-1:0] noise;
    total_data_t            chain_head;
    total_data_t            chain_entry;
    total_data_t            cand_cost;
    total_data_t            best_cost;
    node_idx_t              best_node;
    node_idx_t              visit_idx;
    best_t                  best;
    logic [23:0]            steps;
    logic                   load;
    logic                   last;
    logic                   step;
    logic                   cand_valid;
    logic                   clear_best;
    logic                   running;

    // base distance of the visited replica plus the noise of its advanced generator
    assign cand_cost = chain_entry + total_data_t'(noise);
    assign best      = best_t'{node: best_node, cost: best_cost};

    bus_if #(.node_num(node_num)) i_bus_if (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .seeds_i(seeds), .chain_head_i(chain_head), .best_i(best), .running_i(running),
        .wr_cmd_o(wr_cmd), .rd_cmd_o(rd_cmd)
    );

    run_ctrl i_run_ctrl (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .wr_cmd_i(wr_cmd), .last_i(last), .load_o(load), .steps_o(steps),
        .step_o(step), .cand_valid_o(cand_valid), .clear_best_o(clear_best),
        .running_o(running)
    );

    step_counter #(.node_num(node_num)) i_step_counter (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .load_i(load), .steps_i(steps), .step_i(step),
        .index_o(visit_idx), .last_o(last)
    );

    seed_bank #(.node_num(node_num)) i_seed_bank (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .wr_cmd_i(wr_cmd), .step_i(step), .index_i(visit_idx),
        .noise_o(noise), .seeds_o(seeds)
    );

    distance_chain #(.node_num(node_num)) i_distance_chain (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .wr_cmd_i(wr_cmd), .rd_cmd_i(rd_cmd), .index_i(visit_idx),
        .entry_o(chain_entry), .head_o(chain_head)
    );

    min_tracker #(.payload_t(node_idx_t)) i_min_tracker (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .clear_i(clear_best), .valid_i(cand_valid),
        .cost_i(cand_cost), .payload_i(visit_idx),
        .best_cost_o(best_cost), .best_payload_o(best_node)
    );

endmodule

//--- testbench/tb_replica.sv
// testbench of the replica engine
// drives the AXI-Lite slave and compares readbacks with a reference model of the run

module tb_replica
    import replica_pkg::*;
();

    localparam int node_num = 4;
    // about 35 bus transfers of a few cycles each plus a 20 cycle run, with a wide margin
    localparam int cycle_limit = 4000;
    // AXI OKAY response code
    localparam logic [1:0] okay_resp = 2'b00;

    typedef enum logic [1:0] {
        k_total,
        k_seed,
        k_best,
        k_flag
    } kind_e;

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready_o;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        wvalid;
    logic        wready_o;
    logic [1:0]  bresp_o;
    logic        bvalid_o;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready_o;
    logic [63:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        rvalid_o;
    logic        rready;

    integer      rand_seed;
    int          cycle_count;
    seed_t       ref_seeds[node_num];
    total_data_t ref_chain[$];
    total_data_t pushed[node_num];
    best_t       ref_best;

    // expected and actual readbacks waiting for the checking process
    kind_e       kind_q[$];
    logic [63:0] exp_q[$];
    logic [63:0] got_q[$];
    string       what_q[$];

    replica_top #(.node_num(node_num)) i_replica_top (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o,
        .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o,
        .bresp_o, .bvalid_o, .bready_i(bready),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i(rready)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
    end

    always #10 S_AXI_ACLK = ~S_AXI_ACLK;

    always @(posedge S_AXI_ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the test did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_total(input total_data_t got, input total_data_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_seed(input seed_t got, input seed_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_best(input best_t got, input best_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got cost %0d replica %0d, expected cost %0d replica %0d",
                                   what, got.cost, got.node, exp.cost, exp.node));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    always @(negedge S_AXI_ACLK) begin
        while (kind_q.size() != 0) begin
            case (kind_q[0])
                k_total: check_total(got_q[0][31:0], exp_q[0][31:0], what_q[0]);
                k_seed:  check_seed(got_q[0], exp_q[0], what_q[0]);
                k_best:  check_best(best_t'(got_q[0][39:0]), best_t'(exp_q[0][39:0]), what_q[0]);
                default: check_flag(got_q[0][0], exp_q[0][0], what_q[0]);
            endcase
            void'(kind_q.pop_front());
            void'(exp_q.pop_front());
            void'(got_q.pop_front());
            void'(what_q.pop_front());
        end
    end

    task automatic expect_read(input kind_e kind, input logic [63:0] exp,
                               input logic [63:0] got, input string what);
        kind_q.push_back(kind);
        exp_q.push_back(exp);
        got_q.push_back(got);
        what_q.push_back(what);
    endtask

    function automatic seed_t ref_xorshift(input seed_t s);
        seed_t t;
        t = s ^ (s << 13);
        t = t ^ (t >> 7);
        return t ^ (t << 17);
    endfunction

    // each sweep visits the replicas in order, a count of zero starts nothing
    task automatic ref_run_model(input int count);
        total_data_t cost;
        if (count != 0) begin
            ref_best.cost = '1;
            ref_best.node = '0;
            for (int s = 0; s < count; s++) begin
                for (int r = 0; r < node_num; r++) begin
                    ref_seeds[r] = ref_xorshift(ref_seeds[r]);
                    cost = ref_chain[r] + total_data_t'(ref_seeds[r][noise_width-1:0]);
                    if (cost < ref_best.cost) begin
                        ref_best.cost = cost;
                        ref_best.node = node_idx_t'(r);
                    end
                end
            end
        end
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [63:0] data, input int hold);
        logic aw_take;
        logic w_take;
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge S_AXI_ACLK);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 8'hff;
        wvalid  = 1'b1;
        bready  = 1'b0;
        while (!(aw_done && w_done)) begin
            // the ready outputs follow the slave state only and hold until the next edge
            aw_take = awvalid && awready_o;
            w_take  = wvalid && wready_o;
            @(negedge S_AXI_ACLK);
            if (aw_take) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_take) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
        while (!bvalid_o) @(negedge S_AXI_ACLK);
        check_resp(bresp_o, okay_resp, "write response code");
        repeat (hold) begin
            @(negedge S_AXI_ACLK);
            if (!bvalid_o) report_error("write response dropped while BREADY was low");
        end
        bready = 1'b1;
        @(negedge S_AXI_ACLK);
        bready = 1'b0;
        if (bvalid_o) report_error("write response still valid after BREADY");
    endtask

    task automatic axi_read(input logic [15:0] addr, input int hold, output logic [63:0] data);
        logic take;
        int   lat;
        take    = 1'b0;
        @(negedge S_AXI_ACLK);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        while (!take) begin
            // AW and W valid stay low here, so arready holds until the next edge
            take = arready_o;
            @(negedge S_AXI_ACLK);
        end
        arvalid = 1'b0;
        lat = 1;
        while (!rvalid_o) begin
            @(negedge S_AXI_ACLK);
            lat++;
        end
        if (lat != 2) begin
            report_error($sformatf("RVALID came %0d cycles after the AR accept, expected 2", lat));
        end
        check_resp(rresp_o, okay_resp, "read response code");
        data = rdata_o;
        repeat (hold) begin
            @(negedge S_AXI_ACLK);
            if (!rvalid_o || rdata_o !== data) report_error("read data changed while RREADY was low");
        end
        rready = 1'b1;
        @(negedge S_AXI_ACLK);
        rready = 1'b0;
        if (rvalid_o) report_error("read response still valid after RREADY");
    endtask

    initial begin
        logic [63:0] got;
        int          run_start;
        rand_seed     = 39;
        cycle_count   = 0;
        S_AXI_ARESETN = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int n = 0; n < node_num; n++) begin
            ref_chain.push_back('0);
        end
        repeat (3) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;

        for (int n = 0; n < node_num; n++) begin
            ref_seeds[n] = {$random(rand_seed), $random(rand_seed)};
            axi_write(16'h1000 + 16'(n * 8), ref_seeds[n], 0);
        end
        for (int n = 0; n < node_num; n++) begin
            axi_read(16'h1000 + 16'(n * 8), 0, got);
            expect_read(k_seed, ref_seeds[n], got, $sformatf("seed %0d readback", n));
        end

        // small distances let the noise bits decide the minimum
        for (int n = 0; n < node_num; n++) begin
            pushed[n] = total_data_t'($random(rand_seed)) & 32'h1ff;
            axi_write(16'h2000, {32'b0, pushed[n]}, 0);
            void'(ref_chain.pop_front());
            ref_chain.push_back(pushed[n]);
        end
        for (int n = 0; n <= node_num; n++) begin
            axi_read(16'h2000, 0, got);
            expect_read(k_total, {32'b0, pushed[n % node_num]}, got,
                        $sformatf("chain read %0d", n));
            ref_chain.push_back(ref_chain.pop_front());
        end

        axi_write(16'h0000, 64'd5, 0);
        run_start = cycle_count;
        ref_run_model(5);
        axi_read(16'h0000, 0, got);
        expect_read(k_flag, 64'd1, got, "running just after the start");
        while (got[0] !== 1'b0) begin
            axi_read(16'h0000, 0, got);
        end
        if (cycle_count - run_start < 5 * node_num) begin
            report_error($sformatf("run ended after %0d cycles, expected at least %0d",
                                   cycle_count - run_start, 5 * node_num));
        end
        for (int n = 0; n < node_num; n++) begin
            axi_read(16'h1000 + 16'(n * 8), 0, got);
            expect_read(k_seed, ref_seeds[n], got, $sformatf("seed %0d after the run", n));
        end
        axi_read(16'h4000, 0, got);
        expect_read(k_best, {24'b0, ref_best}, got, "best after the run");

        // responses held back by the host, and a zero count that must not clear the best
        axi_write(16'h0000, 64'd0, 6);
        ref_run_model(0);
        axi_read(16'h0000, 4, got);
        expect_read(k_flag, 64'd0, got, "running after a zero count");
        axi_read(16'h4000, 5, got);
        expect_read(k_best, {24'b0, ref_best}, got, "best after a zero count");
        axi_read(16'h1010, 3, got);
        expect_read(k_seed, ref_seeds[2], got, "seed 2 with RREADY held low");

        while (kind_q.size() != 0) @(negedge S_AXI_ACLK);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- project.f
common/replica_pkg.sv
common/bus_pkg.sv
bus_if/bus_if.sv
src/run_ctrl.sv
src/step_counter.sv
src/seed_bank.sv
src/distance_chain.sv
src/min_tracker.sv
src/replica_top.sv
testbench/tb_replica.sv

//--- run_sim.sh
#!/bin/sh
# build and run the replica engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_replica --Mdir obj_dir -f project.f

output=$(./obj_dir/Vtb_replica 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
